/* alu.sv */
// Combinational ALU for the execute stage with compare flags used by branch resolution
`timescale 1ns/1ps
`include "proc_cfg.svh"

module alu (
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    input  proc_pkg::alu_fn_e fn,
    input  logic [4:0]        shamt,
    output logic [`XLEN-1:0]  result,
    output logic              not_equal,
    output logic              less_than
);
    logic [`XLEN-1:0] diff;

    assign diff = a - b;
    assign not_equal = |diff;
    // When the signs differ the negative operand is the smaller one
    assign less_than = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN-1];

    always_comb begin
        case (fn)
            proc_pkg::FN_ADD: result = a + b;
            proc_pkg::FN_SUB: result = diff;
            proc_pkg::FN_AND: result = a & b;
            proc_pkg::FN_OR:  result = a | b;
            proc_pkg::FN_SLL: result = a << shamt;
            proc_pkg::FN_SRA: result = $signed(a) >>> shamt;
            default:          result = '0;
        endcase
    end

endmodule

/* decode_unit.sv */
// Decode stage with register file read, writeback bypass and load-use detection, used by the core
`timescale 1ns/1ps
`include "proc_cfg.svh"

module decode_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic [`XLEN-1:0]   fd_pc1,
    input  logic [`XLEN-1:0]   fd_insn,
    input  logic               redirect,
    output logic [`REG_AW-1:0] rf_raddr_a,
    output logic [`REG_AW-1:0] rf_raddr_b,
    input  logic [`XLEN-1:0]   rf_rdata_a,
    input  logic [`XLEN-1:0]   rf_rdata_b,
    bypass_if.consumer         byp,
    dx_if.producer             dx,
    output logic               load_stall
);
    proc_pkg::opcode_e  opc;
    proc_pkg::opcode_e  x_opc;
    logic               b_reads_rd;
    logic               uses_a;
    logic               uses_b;
    logic [`REG_AW-1:0] x_rd;
    logic [`XLEN-1:0]   opa;
    logic [`XLEN-1:0]   opb;

    assign opc = proc_pkg::opcode_e'(fd_insn[`OPC_HI:`OPC_LO]);

    // Branches, jr and sw carry their second source in the rd field
    assign b_reads_rd = opc inside {proc_pkg::OPC_BNE, proc_pkg::OPC_BLT,
                                    proc_pkg::OPC_JR, proc_pkg::OPC_SW};
    assign uses_a = opc inside {proc_pkg::OPC_ALU, proc_pkg::OPC_ADDI, proc_pkg::OPC_LW,
                                proc_pkg::OPC_SW, proc_pkg::OPC_BNE, proc_pkg::OPC_BLT};
    assign uses_b = (opc == proc_pkg::OPC_ALU) || b_reads_rd;

    assign rf_raddr_a = fd_insn[`RS_HI -: `REG_AW];
    assign rf_raddr_b = b_reads_rd ? fd_insn[`RD_HI -: `REG_AW] : fd_insn[`RT_HI -: `REG_AW];

    // Same-cycle writeback is not yet visible in the register file
    assign opa = (byp.w_we && byp.w_rd == rf_raddr_a && rf_raddr_a != '0) ? byp.w_data
                                                                           : rf_rdata_a;
    assign opb = (byp.w_we && byp.w_rd == rf_raddr_b && rf_raddr_b != '0) ? byp.w_data
                                                                           : rf_rdata_b;

    // Load in execute feeding this instruction
    assign x_opc = proc_pkg::opcode_e'(dx.insn[`OPC_HI:`OPC_LO]);
    assign x_rd = dx.insn[`RD_HI -: `REG_AW];
    assign load_stall = (x_opc == proc_pkg::OPC_LW) && (x_rd != '0) &&
                        ((uses_a && x_rd == rf_raddr_a) || (uses_b && x_rd == rf_raddr_b));

    always_ff @(posedge clock) begin
        if (!rst_n)
            dx.insn <= '0;
        else if (redirect || load_stall)
            dx.insn <= '0;
        else
            dx.insn <= fd_insn;
    end

    always_ff @(posedge clock) begin
        dx.pc1 <= fd_pc1;
        dx.opa <= opa;
        dx.opb <= opb;
    end

endmodule

/* execute_unit.sv */
// Execute stage with operand forwarding, ALU and control-flow resolution, used by the core
`timescale 1ns/1ps
`include "proc_cfg.svh"

module execute_unit (
    input  logic             clock,
    input  logic             rst_n,
    dx_if.consumer           dx,
    bypass_if.consumer       byp,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] xm_result,
    output logic [`XLEN-1:0] xm_store,
    output logic [`XLEN-1:0] xm_insn
);
    proc_pkg::opcode_e  opc;
    proc_pkg::alu_fn_e  fn;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] src_b;
    logic [`XLEN-1:0]   imm_ext;
    logic [`XLEN-1:0]   fwd_a;
    logic [`XLEN-1:0]   fwd_b;
    logic [`XLEN-1:0]   alu_b;
    logic [`XLEN-1:0]   alu_out;
    logic [`XLEN-1:0]   branch_pc;
    logic [`XLEN-1:0]   target_pc;
    logic               use_imm;
    logic               is_branch;
    logic               ne;
    logic               lt;
    logic               taken;

    assign opc = proc_pkg::opcode_e'(dx.insn[`OPC_HI:`OPC_LO]);
    assign use_imm = opc inside {proc_pkg::OPC_ADDI, proc_pkg::OPC_LW, proc_pkg::OPC_SW};
    assign is_branch = (opc == proc_pkg::OPC_BNE) || (opc == proc_pkg::OPC_BLT);

    assign rs = dx.insn[`RS_HI -: `REG_AW];
    assign src_b = (is_branch || opc inside {proc_pkg::OPC_JR, proc_pkg::OPC_SW})
                   ? dx.insn[`RD_HI -: `REG_AW] : dx.insn[`RT_HI -: `REG_AW];

    // Youngest producer first; a load in memory has no data yet
    assign fwd_a = (byp.m_we && !byp.m_is_load && byp.m_rd == rs) ? byp.m_result :
                   (byp.w_we && byp.w_rd == rs) ? byp.w_data : dx.opa;
    assign fwd_b = (byp.m_we && !byp.m_is_load && byp.m_rd == src_b) ? byp.m_result :
                   (byp.w_we && byp.w_rd == src_b) ? byp.w_data : dx.opb;

    assign imm_ext = {{(`XLEN-`IMM_W){dx.insn[`IMM_W-1]}}, dx.insn[`IMM_W-1:0]};
    assign alu_b = use_imm ? imm_ext : fwd_b;

    always_comb begin
        if (use_imm)
            fn = proc_pkg::FN_ADD;
        else if (is_branch)
            fn = proc_pkg::FN_SUB;
        else
            fn = proc_pkg::alu_fn_e'(dx.insn[`FN_HI -: 5]);
    end

    alu u_alu (
        .a         (fwd_a),
        .b         (alu_b),
        .fn        (fn),
        .shamt     (dx.insn[`SH_HI -: 5]),
        .result    (alu_out),
        .not_equal (ne),
        .less_than (lt)
    );

    // ALU computes rs - rd so blt is taken when rs is strictly greater
    assign taken = ((opc == proc_pkg::OPC_BNE) && ne) ||
                   ((opc == proc_pkg::OPC_BLT) && !lt && ne);
    assign redirect = taken || opc inside {proc_pkg::OPC_J, proc_pkg::OPC_JAL, proc_pkg::OPC_JR};

    assign branch_pc = dx.pc1 + imm_ext;
    assign target_pc = {{(`XLEN-`TGT_W){1'b0}}, dx.insn[`TGT_W-1:0]};
    assign redirect_pc = (opc == proc_pkg::OPC_JR) ? fwd_b :
                         (is_branch ? branch_pc : target_pc);

    always_ff @(posedge clock) begin
        if (!rst_n)
            xm_insn <= '0;
        else
            xm_insn <= dx.insn;
    end

    always_ff @(posedge clock) begin
        xm_result <= (opc == proc_pkg::OPC_JAL) ? dx.pc1 : alu_out;
        xm_store <= fwd_b;
    end

endmodule

/* fetch_unit.sv */
// Fetch stage holding the PC and the fetch/decode latch, instantiated by the core top level
`timescale 1ns/1ps
`include "proc_cfg.svh"

module fetch_unit (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             redirect,
    input  logic             load_stall,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output logic [`XLEN-1:0] fd_pc1,
    output logic [`XLEN-1:0] fd_insn
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus1;
    logic [`XLEN-1:0] next_pc;

    assign pc_plus1 = pc + 1'b1;
    assign next_pc = redirect ? redirect_pc : pc_plus1;
    assign imem_addr = pc;

    // A redirect wins over a load stall
    always_ff @(posedge clock) begin
        if (!rst_n)
            pc <= `RESET_PC;
        else if (redirect || !load_stall)
            pc <= next_pc;
    end

    // Squash the word being fetched when execute redirects
    always_ff @(posedge clock) begin
        if (!rst_n)
            fd_insn <= '0;
        else if (redirect)
            fd_insn <= '0;
        else if (!load_stall)
            fd_insn <= imem_data;
    end

    always_ff @(posedge clock) begin
        if (!load_stall)
            fd_pc1 <= pc_plus1;
    end

endmodule

/* mem_wb_unit.sv */
// Memory and writeback stages driving data memory and register file writes, used by the core
`timescale 1ns/1ps
`include "proc_cfg.svh"

module mem_wb_unit (
    input  logic               clock,
    input  logic               rst_n,
    input  logic [`XLEN-1:0]   xm_result,
    input  logic [`XLEN-1:0]   xm_store,
    input  logic [`XLEN-1:0]   xm_insn,
    output logic [`XLEN-1:0]   dmem_addr,
    output logic [`XLEN-1:0]   dmem_wdata,
    output logic               dmem_wren,
    input  logic [`XLEN-1:0]   dmem_rdata,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_wreg,
    output logic [`XLEN-1:0]   rf_wdata,
    bypass_if.producer         byp
);
    logic [`REG_AW-1:0] m_dest;
    logic [`XLEN-1:0]   mw_result;
    logic [`XLEN-1:0]   mw_load;
    logic [`XLEN-1:0]   mw_insn;

    function automatic proc_pkg::opcode_e opcode_of(input logic [`XLEN-1:0] insn);
        return proc_pkg::opcode_e'(insn[`OPC_HI:`OPC_LO]);
    endfunction

    function automatic logic writes_reg(input logic [`XLEN-1:0] insn);
        return opcode_of(insn) inside {proc_pkg::OPC_ALU, proc_pkg::OPC_ADDI,
                                       proc_pkg::OPC_LW, proc_pkg::OPC_JAL};
    endfunction

    // jal links into the fixed return register
    function automatic logic [`REG_AW-1:0] dest_of(input logic [`XLEN-1:0] insn);
        return (opcode_of(insn) == proc_pkg::OPC_JAL) ? `LINK_REG : insn[`RD_HI -: `REG_AW];
    endfunction

    assign dmem_addr = xm_result;
    assign dmem_wren = (opcode_of(xm_insn) == proc_pkg::OPC_SW);
    assign dmem_wdata = (dmem_wren && rf_we && rf_wreg == xm_insn[`RD_HI -: `REG_AW])
                        ? rf_wdata : xm_store;

    always_ff @(posedge clock) begin
        if (!rst_n)
            mw_insn <= '0;
        else
            mw_insn <= xm_insn;
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load <= dmem_rdata;
    end

    assign rf_wreg = dest_of(mw_insn);
    assign rf_wdata = (opcode_of(mw_insn) == proc_pkg::OPC_LW) ? mw_load : mw_result;
    assign rf_we = writes_reg(mw_insn) && (rf_wreg != '0);

    // Bypass sources for decode and execute
    assign m_dest = dest_of(xm_insn);
    assign byp.m_result = xm_result;
    assign byp.m_rd = m_dest;
    assign byp.m_we = writes_reg(xm_insn) && (m_dest != '0);
    assign byp.m_is_load = (opcode_of(xm_insn) == proc_pkg::OPC_LW);
    assign byp.w_data = rf_wdata;
    assign byp.w_rd = rf_wreg;
    assign byp.w_we = rf_we;

endmodule

/* pipeline_assert.sv */
// Port-level checks on the core, bound to every pipeline_core instance for simulation
`timescale 1ns/1ps
`include "proc_cfg.svh"

module pipeline_assert (
    input logic               clock,
    input logic               rst_n,
    input logic [`XLEN-1:0]   imem_addr,
    input logic               rf_we,
    input logic [`REG_AW-1:0] rf_wreg,
    input logic               dmem_wren
);

    // Write enables stay known once reset is released
    we_known: assert property (@(posedge clock) disable iff (!rst_n)
        !$isunknown({rf_we, dmem_wren}))
        else $error("Write enable is unknown out of reset");

    // r0 is never a write target
    no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
        rf_we |-> (rf_wreg != '0))
        else $error("Register write issued to r0");

    // First fetch after reset comes from the reset vector
    reset_fetch: assert property (@(posedge clock)
        $rose(rst_n) |-> (imem_addr == `RESET_PC))
        else $error("First fetch after reset is not at the reset address");

endmodule

bind pipeline_core pipeline_assert u_assert (
    .clock     (clock),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .rf_we     (rf_we),
    .rf_wreg   (rf_wreg),
    .dmem_wren (dmem_wren)
);

/* pipeline_core.sv */
// Five-stage core top level connecting the stages to external memories and the register file
`timescale 1ns/1ps
`include "proc_cfg.svh"

module pipeline_core (
    input  logic               clock,
    input  logic               rst_n,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic [`XLEN-1:0]   imem_data,
    output logic [`XLEN-1:0]   dmem_addr,
    output logic [`XLEN-1:0]   dmem_wdata,
    output logic               dmem_wren,
    input  logic [`XLEN-1:0]   dmem_rdata,
    output logic               rf_we,
    output logic [`REG_AW-1:0] rf_wreg,
    output logic [`REG_AW-1:0] rf_raddr_a,
    output logic [`REG_AW-1:0] rf_raddr_b,
    output logic [`XLEN-1:0]   rf_wdata,
    input  logic [`XLEN-1:0]   rf_rdata_a,
    input  logic [`XLEN-1:0]   rf_rdata_b
);
    logic             redirect;
    logic             load_stall;
    logic [`XLEN-1:0] redirect_pc;
    logic [`XLEN-1:0] fd_pc1;
    logic [`XLEN-1:0] fd_insn;
    logic [`XLEN-1:0] xm_result;
    logic [`XLEN-1:0] xm_store;
    logic [`XLEN-1:0] xm_insn;

    bypass_if byp ();
    dx_if     dx ();

    fetch_unit u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .load_stall  (load_stall),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fd_pc1      (fd_pc1),
        .fd_insn     (fd_insn)
    );

    decode_unit u_decode (
        .clock      (clock),
        .rst_n      (rst_n),
        .fd_pc1     (fd_pc1),
        .fd_insn    (fd_insn),
        .redirect   (redirect),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b),
        .byp        (byp),
        .dx         (dx),
        .load_stall (load_stall)
    );

    execute_unit u_execute (
        .clock       (clock),
        .rst_n       (rst_n),
        .dx          (dx),
        .byp         (byp),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm_result   (xm_result),
        .xm_store    (xm_store),
        .xm_insn     (xm_insn)
    );

    mem_wb_unit u_mem_wb (
        .clock      (clock),
        .rst_n      (rst_n),
        .xm_result  (xm_result),
        .xm_store   (xm_store),
        .xm_insn    (xm_insn),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wren  (dmem_wren),
        .dmem_rdata (dmem_rdata),
        .rf_we      (rf_we),
        .rf_wreg    (rf_wreg),
        .rf_wdata   (rf_wdata),
        .byp        (byp)
    );

endmodule

/* proc_cfg.svh */
// Widths, instruction field positions and reset values, included by every core source
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Data and address width
`define XLEN 32
// Register index width
`define REG_AW 5

// Instruction fields given as the top bit of each field
`define OPC_HI 31
`define OPC_LO 27
`define RD_HI 26
`define RS_HI 21
`define RT_HI 16
`define SH_HI 11
`define FN_HI 6
`define IMM_W 17
`define TGT_W 27

`define LINK_REG 5'd31
`define RESET_PC 32'd0

`endif

/* proc_ifs.sv */
// Pipeline interfaces for the bypass network and the decode/execute latch, used inside the core
`timescale 1ns/1ps
`include "proc_cfg.svh"

interface bypass_if;
    // Memory stage result and destination
    logic [`XLEN-1:0]   m_result;
    logic [`REG_AW-1:0] m_rd;
    logic               m_we;
    logic               m_is_load;
    // Writeback stage data and destination
    logic [`XLEN-1:0]   w_data;
    logic [`REG_AW-1:0] w_rd;
    logic               w_we;

    modport producer (output m_result, m_rd, m_we, m_is_load, w_data, w_rd, w_we);
    modport consumer (input m_result, m_rd, m_we, m_is_load, w_data, w_rd, w_we);
endinterface

interface dx_if;
    logic [`XLEN-1:0] pc1;
    logic [`XLEN-1:0] insn;
    // Register operands as read in decode
    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;

    modport producer (output pc1, insn, opa, opb);
    modport consumer (input pc1, insn, opa, opb);
endinterface

/* proc_pkg.sv */
// Shared opcode and ALU function types, referenced by scoped name from the core and testbench
package proc_pkg;

    // Major opcodes in bits 31:27
    typedef enum logic [4:0] {
        OPC_ALU  = 5'd0,
        OPC_J    = 5'd1,
        OPC_BNE  = 5'd2,
        OPC_JAL  = 5'd3,
        OPC_JR   = 5'd4,
        OPC_ADDI = 5'd5,
        OPC_BLT  = 5'd6,
        OPC_SW   = 5'd7,
        OPC_LW   = 5'd8
    } opcode_e;

    // ALU function field in bits 6:2 of register operations
    typedef enum logic [4:0] {
        FN_ADD = 5'd0,
        FN_SUB = 5'd1,
        FN_AND = 5'd2,
        FN_OR  = 5'd3,
        FN_SLL = 5'd4,
        FN_SRA = 5'd5
    } alu_fn_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the core testbench with Verilator, runs it into sim.log and fails on a reported error

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline_core \
    -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation log has no final result line"
    exit 1
fi
exit 0

/* tb.f */
+incdir+.
proc_pkg.sv
proc_ifs.sv
alu.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
pipeline_core.sv
pipeline_assert.sv
tb_pipeline_core.sv

/* tb_pipeline_core.sv */
// Self-checking testbench for the core, modelling memories and register file against a reference
`timescale 1ns/1ps
`include "proc_cfg.svh"

module tb_pipeline_core;

    localparam int NUM_TESTS = 25;
    // Longest program budget in cycles including reset
    localparam int TEST_CYCLES = 120;
    localparam int STEP_LIMIT = 200;

    logic               clock;
    logic               rst_n;
    logic [`XLEN-1:0]   imem_addr;
    logic [`XLEN-1:0]   imem_data;
    logic [`XLEN-1:0]   dmem_addr;
    logic [`XLEN-1:0]   dmem_wdata;
    logic               dmem_wren;
    logic [`XLEN-1:0]   dmem_rdata;
    logic               rf_we;
    logic [`REG_AW-1:0] rf_wreg;
    logic [`REG_AW-1:0] rf_raddr_a;
    logic [`REG_AW-1:0] rf_raddr_b;
    logic [`XLEN-1:0]   rf_wdata;
    logic [`XLEN-1:0]   rf_rdata_a;
    logic [`XLEN-1:0]   rf_rdata_b;

    logic [`XLEN-1:0]   imem [0:255];
    logic [`XLEN-1:0]   dmem [0:255];
    logic [`XLEN-1:0]   rf [0:31];
    logic               init_req;
    logic               active;
    logic [`XLEN-1:0]   reg_salt;
    integer             seed;
    int                 error_count;
    int                 errors_before;
    int                 tests_run;
    int                 tests_failed;
    int                 prog_len;
    string              test_name;

    // Expected register writes and stores in program order
    logic [`REG_AW-1:0] exp_wreg [$];
    logic [`XLEN-1:0]   exp_wdata [$];
    logic [`XLEN-1:0]   exp_saddr [$];
    logic [`XLEN-1:0]   exp_sdata [$];

    pipeline_core UUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wren  (dmem_wren),
        .dmem_rdata (dmem_rdata),
        .rf_we      (rf_we),
        .rf_wreg    (rf_wreg),
        .rf_raddr_a (rf_raddr_a),
        .rf_raddr_b (rf_raddr_b),
        .rf_wdata   (rf_wdata),
        .rf_rdata_a (rf_rdata_a),
        .rf_rdata_b (rf_rdata_b)
    );

    assign imem_data = imem[imem_addr[7:0]];
    assign dmem_rdata = dmem[dmem_addr[7:0]];
    assign rf_rdata_a = rf[rf_raddr_a];
    assign rf_rdata_b = rf[rf_raddr_b];

    function automatic logic [`XLEN-1:0] reg_init(input int idx);
        if (idx == 0)
            return '0;
        return (idx * 32'h0913_5a27) ^ reg_salt;
    endfunction

    // Fill pattern keyed on the full word address
    function automatic logic [`XLEN-1:0] mem_fill(input int addr);
        return 32'hd00d_0000 ^ (addr * 32'h0001_0203);
    endfunction

    function automatic logic [31:0] rtype_word(input int fn, input int rd, input int rs,
                                               input int rt, input int sh);
        return {proc_pkg::OPC_ALU, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn[4:0], 2'b00};
    endfunction

    function automatic logic [31:0] itype_word(input proc_pkg::opcode_e opc, input int rd,
                                               input int rs, input int imm);
        return {opc, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] jump_word(input proc_pkg::opcode_e opc, input int tgt);
        return {opc, tgt[26:0]};
    endfunction

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Register file and data memory reload while init_req is high
    always @(posedge clock) begin
        if (init_req) begin
            for (int i = 0; i < 32; i++)
                rf[i[4:0]] <= reg_init(i);
            for (int i = 0; i < 256; i++)
                dmem[i[7:0]] <= mem_fill(i);
        end else begin
            if (rf_we)
                rf[rf_wreg] <= rf_wdata;
            if (dmem_wren)
                dmem[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    // Instruction-level model of the program in imem
    function automatic void run_reference();
        logic [`XLEN-1:0] regs [0:31];
        logic [`XLEN-1:0] mem [0:255];
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] insn;
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] t;
        logic [`XLEN-1:0] imm;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wr_val;
        logic [4:0]       wr_dest;
        logic             wr_en;
        logic             done;
        int               steps;
        int               i;
        for (i = 0; i < 32; i++)
            regs[i[4:0]] = reg_init(i);
        for (i = 0; i < 256; i++)
            mem[i[7:0]] = mem_fill(i);
        exp_wreg.delete();
        exp_wdata.delete();
        exp_saddr.delete();
        exp_sdata.delete();
        pc = `RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < STEP_LIMIT) begin
            insn = imem[pc[7:0]];
            a = regs[insn[21:17]];
            b = regs[insn[26:22]];
            t = regs[insn[16:12]];
            imm = {{15{insn[16]}}, insn[16:0]};
            addr = a + imm;
            next_pc = pc + 32'd1;
            wr_en = 1'b0;
            wr_dest = insn[26:22];
            wr_val = '0;
            case (proc_pkg::opcode_e'(insn[31:27]))
                proc_pkg::OPC_ALU: begin
                    wr_en = 1'b1;
                    case (proc_pkg::alu_fn_e'(insn[6:2]))
                        proc_pkg::FN_ADD: wr_val = a + t;
                        proc_pkg::FN_SUB: wr_val = a - t;
                        proc_pkg::FN_AND: wr_val = a & t;
                        proc_pkg::FN_OR:  wr_val = a | t;
                        proc_pkg::FN_SLL: wr_val = a << insn[11:7];
                        proc_pkg::FN_SRA: wr_val = $signed(a) >>> insn[11:7];
                        default:          wr_val = '0;
                    endcase
                end
                proc_pkg::OPC_ADDI: begin
                    wr_en = 1'b1;
                    wr_val = addr;
                end
                proc_pkg::OPC_LW: begin
                    wr_en = 1'b1;
                    wr_val = mem[addr[7:0]];
                end
                proc_pkg::OPC_SW: begin
                    mem[addr[7:0]] = b;
                    exp_saddr.push_back(addr);
                    exp_sdata.push_back(b);
                end
                proc_pkg::OPC_BNE: begin
                    if (a != b)
                        next_pc = pc + 32'd1 + imm;
                end
                proc_pkg::OPC_BLT: begin
                    // Taken when rd is less than rs, signed
                    if ($signed(b) < $signed(a))
                        next_pc = pc + 32'd1 + imm;
                end
                proc_pkg::OPC_J: begin
                    next_pc = {5'd0, insn[26:0]};
                    done = (next_pc == pc);
                end
                proc_pkg::OPC_JAL: begin
                    wr_en = 1'b1;
                    wr_dest = 5'd31;
                    wr_val = pc + 32'd1;
                    next_pc = {5'd0, insn[26:0]};
                end
                proc_pkg::OPC_JR: next_pc = b;
                default: wr_en = 1'b0;
            endcase
            if (wr_en && wr_dest != 5'd0) begin
                regs[wr_dest] = wr_val;
                exp_wreg.push_back(wr_dest);
                exp_wdata.push_back(wr_val);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s expected %h actual %h", sig, expected, actual);
            error_count++;
        end
    endtask

    // Compares each write and store with the head of its expected list
    always @(posedge clock) begin
        if (active && rf_we) begin
            assert (exp_wreg.size() != 0) else begin
                $display("Register write to r%0d arrived when none was expected", rf_wreg);
                error_count++;
            end
            if (exp_wreg.size() != 0) begin
                check_value("rf_wreg", {27'd0, exp_wreg[0]}, {27'd0, rf_wreg});
                check_value("rf_wdata", exp_wdata[0], rf_wdata);
                void'(exp_wreg.pop_front());
                void'(exp_wdata.pop_front());
            end
        end
        if (active && dmem_wren) begin
            assert (exp_saddr.size() != 0) else begin
                $display("Store to address %h arrived when none was expected", dmem_addr);
                error_count++;
            end
            if (exp_saddr.size() != 0) begin
                check_value("dmem_addr", exp_saddr[0], dmem_addr);
                check_value("dmem_wdata", exp_sdata[0], dmem_wdata);
                void'(exp_saddr.pop_front());
                void'(exp_sdata.pop_front());
            end
        end
    end

    task automatic emit(input logic [31:0] word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    // Holds reset for 5 cycles and reloads the memories
    task automatic begin_test(input string name, input logic [31:0] salt);
        test_name = name;
        errors_before = error_count;
        active = 1'b0;
        rst_n = 1'b0;
        reg_salt = salt;
        init_req = 1'b1;
        prog_len = 0;
        for (int i = 0; i < 256; i++)
            imem[i[7:0]] = '0;
        @(negedge clock);
        init_req = 1'b0;
        repeat (4) @(negedge clock);
    endtask

    task automatic run_test();
        emit(jump_word(proc_pkg::OPC_J, prog_len));
        run_reference();
        rst_n = 1'b1;
        active = 1'b1;
        check_value("rf_we", 32'd0, {31'd0, rf_we});
        check_value("dmem_wren", 32'd0, {31'd0, dmem_wren});
        check_value("imem_addr", `RESET_PC, imem_addr);
        while (exp_wreg.size() != 0 || exp_saddr.size() != 0)
            @(negedge clock);
        // Keep comparing until the closing self-jump is fetched again so that
        // late wrong-path writes still meet the compare process
        while (imem_addr != prog_len - 1)
            @(negedge clock);
        while (imem_addr == prog_len - 1)
            @(negedge clock);
        while (imem_addr != prog_len - 1)
            @(negedge clock);
        @(negedge clock);
        active = 1'b0;
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", tests_run, test_name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d mismatches", tests_run, test_name,
                     error_count - errors_before);
        end
    endtask

    // Two writes that only a wrong-path fetch would perform
    task automatic shadow_pair();
        emit(itype_word(proc_pkg::OPC_ADDI, 20, 0, 'h666));
        emit(itype_word(proc_pkg::OPC_ADDI, 21, 0, 'h777));
    endtask

    task automatic random_program();
        int k;
        for (k = 0; k < 12; k++) begin
            case (pick(4))
                0: emit(rtype_word(pick(6), pick(8), pick(8), pick(8), pick(32)));
                1: emit(itype_word(proc_pkg::OPC_ADDI, pick(8), pick(8), $random(seed) % 64));
                2: emit(itype_word(proc_pkg::OPC_LW, pick(8), 0, pick(16)));
                default: emit(itype_word(proc_pkg::OPC_SW, pick(8), 0, pick(16)));
            endcase
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 8);
        $display("Timeout: the tests did not finish within %0d ns", NUM_TESTS * TEST_CYCLES * 8);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        init_req = 1'b1;
        active = 1'b0;
        reg_salt = '0;
        seed = 32'h78c9_604f;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        prog_len = 0;

        begin_test("reset", 0);
        emit(itype_word(proc_pkg::OPC_ADDI, 1, 0, 'h55));
        run_test();

        // Gaps of zero, one and two exercise memory, writeback and decode bypass
        begin_test("alu chain", 0);
        emit(itype_word(proc_pkg::OPC_ADDI, 1, 0, 'h123));
        emit(rtype_word(proc_pkg::FN_ADD, 2, 1, 1, 0));
        emit(rtype_word(proc_pkg::FN_SUB, 3, 2, 1, 0));
        emit(rtype_word(proc_pkg::FN_AND, 4, 3, 2, 0));
        emit(rtype_word(proc_pkg::FN_OR, 5, 4, 1, 0));
        emit(rtype_word(proc_pkg::FN_SLL, 6, 5, 0, 3));
        emit(itype_word(proc_pkg::OPC_ADDI, 8, 6, -7000));
        emit(rtype_word(proc_pkg::FN_SRA, 9, 8, 0, 1));
        emit(rtype_word(proc_pkg::FN_SUB, 10, 9, 6, 0));
        emit(rtype_word(proc_pkg::FN_SRA, 11, 10, 0, 2));
        emit(rtype_word(proc_pkg::FN_ADD, 12, 11, 10, 0));
        emit('0);
        emit(rtype_word(proc_pkg::FN_ADD, 13, 12, 1, 0));
        emit('0);
        emit('0);
        emit(rtype_word(proc_pkg::FN_ADD, 14, 13, 13, 0));
        run_test();

        begin_test("loads and stores", 0);
        emit(itype_word(proc_pkg::OPC_ADDI, 1, 0, 10));
        emit(itype_word(proc_pkg::OPC_LW, 2, 1, 2));
        emit(rtype_word(proc_pkg::FN_ADD, 3, 2, 2, 0));
        emit(itype_word(proc_pkg::OPC_SW, 3, 1, 20));
        emit(itype_word(proc_pkg::OPC_LW, 4, 1, 20));
        emit(itype_word(proc_pkg::OPC_SW, 4, 0, 40));
        emit(itype_word(proc_pkg::OPC_LW, 5, 0, 40));
        emit(rtype_word(proc_pkg::FN_ADD, 6, 5, 4, 0));
        run_test();

        begin_test("branches", 0);
        emit(itype_word(proc_pkg::OPC_ADDI, 1, 0, 3));
        emit(itype_word(proc_pkg::OPC_ADDI, 2, 0, 5));
        emit(itype_word(proc_pkg::OPC_BNE, 2, 1, 2));
        shadow_pair();
        emit(itype_word(proc_pkg::OPC_BNE, 1, 1, 2));
        emit(itype_word(proc_pkg::OPC_ADDI, 22, 0, 'h111));
        emit(itype_word(proc_pkg::OPC_ADDI, 23, 0, 'h112));
        emit(itype_word(proc_pkg::OPC_BLT, 1, 2, 2));
        shadow_pair();
        emit(itype_word(proc_pkg::OPC_BLT, 2, 1, 2));
        emit(itype_word(proc_pkg::OPC_ADDI, 24, 0, 'h113));
        emit(itype_word(proc_pkg::OPC_ADDI, 3, 0, -4));
        emit(itype_word(proc_pkg::OPC_BLT, 3, 1, 2));
        shadow_pair();
        emit(itype_word(proc_pkg::OPC_ADDI, 4, 0, 9));
        emit(itype_word(proc_pkg::OPC_BNE, 1, 4, 2));
        shadow_pair();
        // Backward loop runs three times
        emit(itype_word(proc_pkg::OPC_ADDI, 6, 0, 3));
        emit(itype_word(proc_pkg::OPC_ADDI, 5, 0, 0));
        emit(itype_word(proc_pkg::OPC_ADDI, 5, 5, 1));
        emit(itype_word(proc_pkg::OPC_BLT, 5, 6, -2));
        run_test();

        // Two calls through r31 where the second returns straight away
        begin_test("jumps", 0);
        emit(itype_word(proc_pkg::OPC_ADDI, 1, 0, 1));
        emit(jump_word(proc_pkg::OPC_JAL, 9));
        emit(itype_word(proc_pkg::OPC_ADDI, 2, 1, 100));
        emit(jump_word(proc_pkg::OPC_JAL, 12));
        emit(jump_word(proc_pkg::OPC_J, 14));
        emit(itype_word(proc_pkg::OPC_ADDI, 22, 0, 'h222));
        emit(itype_word(proc_pkg::OPC_ADDI, 23, 0, 'h333));
        emit('0);
        emit('0);
        emit(itype_word(proc_pkg::OPC_ADDI, 3, 1, 7));
        emit(itype_word(proc_pkg::OPC_JR, 31, 0, 0));
        emit('0);
        emit(itype_word(proc_pkg::OPC_JR, 31, 0, 0));
        emit('0);
        run_test();

        for (int n = 0; n < 20; n++) begin
            begin_test($sformatf("random %0d", n), $random(seed));
            random_program();
            run_test();
        end

        $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
